// ==== source/i3c_pkg.sv ====
// Shared widths, register map and bus structs for the I3C controller subsystem; import where needed
package i3c_pkg;

    // Table and bus timing sizes
    localparam int unsigned DatDepth   = 16;
    localparam int unsigned DatAw      = 4;
    localparam int unsigned SclHalfDiv = 4;
    localparam int unsigned SlotCycles = 2 * SclHalfDiv;
    localparam int unsigned SlotCntW   = $clog2(SlotCycles);
    localparam int unsigned FrameBits  = 8;
    localparam int unsigned BitCntW    = $clog2(FrameBits);

    typedef logic [7:0]       csr_addr_t;
    typedef logic [31:0]      csr_data_t;
    typedef logic [DatAw-1:0] dat_idx_t;
    typedef logic [6:0]       dyn_addr_t;

    // Register map
    localparam csr_addr_t CsrAddrCmd     = 8'h04;
    localparam csr_addr_t CsrAddrStatus  = 8'h08;
    localparam csr_addr_t CsrAddrDatBase = 8'h40;

    // Field positions in the command and status registers
    localparam int unsigned CmdRnwBit   = 8;
    localparam int unsigned StatDoneBit = 0;
    localparam int unsigned StatNackBit = 1;
    localparam int unsigned StatDropBit = 2;
    localparam int unsigned StatBusyBit = 3;

    // One device address table word, dyn_addr in the low bits
    typedef struct packed {
        logic [23:0] reserved;
        logic        push_pull;
        dyn_addr_t   dyn_addr;
    } dat_entry_t;

    typedef struct packed {
        logic      req;
        logic      write;
        dat_idx_t  addr;
        csr_data_t wdata;
    } table_req_t;

    typedef struct packed {
        logic      rvalid;
        csr_data_t rdata;
    } table_rsp_t;

    typedef struct packed {
        logic       start;
        logic       rnw;
        dat_entry_t entry;
    } xfer_cmd_t;

    typedef struct packed {
        logic busy;
        logic done;
        logic nack;
    } xfer_stat_t;

    typedef enum logic [2:0] {IDLE, START, BITS, ACK, STOP} ser_state_e;

endpackage

// ==== source/i3c_csr_frontend.sv ====
// Register front end: decodes host accesses, owns the table RAM port and launches address frames
`timescale 1ns/1ps

module i3c_csr_frontend import i3c_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       csr_req_i,
    input  logic       csr_we_i,
    input  csr_addr_t  csr_addr_i,
    input  csr_data_t  csr_wdata_i,
    output csr_data_t  csr_rdata_o,
    output table_req_t table_req_o,
    input  table_rsp_t table_rsp_i,
    output xfer_cmd_t  cmd_o,
    input  xfer_stat_t stat_i,
    output logic       irq_o
);

    logic      dat_hit;
    logic      dat_sel;
    logic      cmd_wr;
    logic      cmd_accept;
    logic      cmd_drop;
    logic      stat_wr;
    logic      fetch_q;
    logic      host_rd_q;
    logic      rnw_q;
    logic      done_q;
    logic      nack_q;
    logic      drop_q;
    csr_data_t status_word;
    csr_data_t rd_mux;
    csr_data_t rdata_q;

    // Table window is 0x40..0x7C, word aligned
    assign dat_hit = (csr_addr_i[7:DatAw+2] == CsrAddrDatBase[7:DatAw+2]) &&
                     (csr_addr_i[1:0] == 2'b00);
    assign dat_sel = csr_req_i && dat_hit;
    assign cmd_wr  = csr_req_i && csr_we_i && (csr_addr_i == CsrAddrCmd);
    assign stat_wr = csr_req_i && csr_we_i && (csr_addr_i == CsrAddrStatus);

    // A fetch in flight counts as busy until the serializer takes over
    assign cmd_drop   = cmd_wr && (stat_i.busy || fetch_q);
    assign cmd_accept = cmd_wr && !cmd_drop;

    always_comb begin
        table_req_o       = '0;
        table_req_o.wdata = csr_wdata_i;
        if (cmd_accept) begin
            table_req_o.req  = 1'b1;
            table_req_o.addr = csr_wdata_i[DatAw-1:0];
        end else if (dat_sel) begin
            table_req_o.req   = 1'b1;
            table_req_o.write = csr_we_i;
            table_req_o.addr  = csr_addr_i[DatAw+1:2];
        end
    end

    // Fetched entry goes straight to the serializer
    assign cmd_o.start = fetch_q && table_rsp_i.rvalid;
    assign cmd_o.rnw   = rnw_q;
    assign cmd_o.entry = dat_entry_t'(table_rsp_i.rdata);

    always_comb begin
        status_word              = '0;
        status_word[StatDoneBit] = done_q;
        status_word[StatNackBit] = nack_q;
        status_word[StatDropBit] = drop_q;
        status_word[StatBusyBit] = stat_i.busy;
    end

    assign rd_mux = (csr_addr_i == CsrAddrStatus) ? status_word : '0;

    always_ff @(posedge clk_i) begin
        if (cmd_accept) begin
            rnw_q <= csr_wdata_i[CmdRnwBit];
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fetch_q   <= 1'b0;
            host_rd_q <= 1'b0;
            done_q    <= 1'b0;
            nack_q    <= 1'b0;
            drop_q    <= 1'b0;
            rdata_q   <= '0;
        end else begin
            fetch_q   <= cmd_accept;
            host_rd_q <= dat_sel && !csr_we_i;
            // Set wins over a W1C in the same cycle
            done_q <= (done_q && !(stat_wr && csr_wdata_i[StatDoneBit])) || stat_i.done;
            nack_q <= (nack_q && !(stat_wr && csr_wdata_i[StatNackBit])) ||
                      (stat_i.done && stat_i.nack);
            drop_q <= (drop_q && !(stat_wr && csr_wdata_i[StatDropBit])) || cmd_drop;
            if (csr_req_i && !csr_we_i && !dat_hit) begin
                rdata_q <= rd_mux;
            end else if (host_rd_q && table_rsp_i.rvalid) begin
                rdata_q <= table_rsp_i.rdata;
            end
        end
    end

    // Table data shows in its first cycle, then is held in rdata_q
    assign csr_rdata_o = (host_rd_q && table_rsp_i.rvalid) ? table_rsp_i.rdata : rdata_q;
    assign irq_o       = done_q;

endmodule

// ==== source/i3c_table_ram.sv ====
// Single-port device address table with one-cycle registered read, driven by the CSR front end
`timescale 1ns/1ps

module i3c_table_ram import i3c_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  table_req_t req_i,
    output table_rsp_t rsp_o
);

    csr_data_t mem_q [DatDepth];
    csr_data_t rdata_q;
    logic      rvalid_q;

    // Storage and read port
    always_ff @(posedge clk_i) begin
        if (req_i.req) begin
            if (req_i.write) begin
                mem_q[req_i.addr] <= req_i.wdata;
            end else begin
                rdata_q <= mem_q[req_i.addr];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= req_i.req && !req_i.write;
        end
    end

    assign rsp_o.rvalid = rvalid_q;
    assign rsp_o.rdata  = rdata_q;

endmodule

// ==== source/i3c_addr_serializer.sv ====
// Address frame engine: START, 7-bit address plus RnW, ACK sample and STOP on SCL/SDA
`timescale 1ns/1ps

module i3c_addr_serializer import i3c_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  xfer_cmd_t  cmd_i,
    output xfer_stat_t stat_o,
    output logic       scl_o,
    output logic       sda_o,
    input  logic       sda_i,
    output logic       sel_od_pp_o
);

    ser_state_e           state_q;
    logic [SlotCntW-1:0]  cnt_q;
    logic [BitCntW-1:0]   bit_q;
    logic [FrameBits-1:0] shift_q;
    logic                 pp_q;
    logic                 nack_q;
    logic                 slot_end;
    logic                 scl_high;
    logic                 launch;

    assign slot_end = (cnt_q == SlotCntW'(SlotCycles - 1));
    // Second half of a slot
    assign scl_high = (cnt_q >= SlotCntW'(SclHalfDiv));
    assign launch   = (state_q == IDLE) && cmd_i.start;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            bit_q   <= '0;
        end else begin
            if (state_q != IDLE) begin
                cnt_q <= slot_end ? '0 : cnt_q + 1'b1;
            end
            case (state_q)
                IDLE: begin
                    if (launch) begin
                        state_q <= START;
                        cnt_q   <= '0;
                    end
                end
                START: begin
                    if (slot_end) begin
                        state_q <= BITS;
                        bit_q   <= '0;
                    end
                end
                BITS: begin
                    if (slot_end) begin
                        bit_q <= bit_q + 1'b1;
                        if (bit_q == BitCntW'(FrameBits - 1)) begin
                            state_q <= ACK;
                        end
                    end
                end
                ACK: begin
                    if (slot_end) begin
                        state_q <= STOP;
                    end
                end
                STOP: begin
                    if (slot_end) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Frame payload, MSB first
    always_ff @(posedge clk_i) begin
        if (launch) begin
            shift_q <= {cmd_i.entry.dyn_addr, cmd_i.rnw};
            pp_q    <= cmd_i.entry.push_pull;
        end else if ((state_q == BITS) && slot_end) begin
            shift_q <= {shift_q[FrameBits-2:0], 1'b0};
        end
        // First cycle after SCL rises in the ACK slot
        if ((state_q == ACK) && (cnt_q == SlotCntW'(SclHalfDiv))) begin
            nack_q <= sda_i;
        end
    end

    always_comb begin
        scl_o = 1'b1;
        sda_o = 1'b1;
        case (state_q)
            // SDA falls while SCL stays high
            START: sda_o = !scl_high;
            BITS: begin
                scl_o = scl_high;
                sda_o = shift_q[FrameBits-1];
            end
            // SDA released for the target
            ACK:  scl_o = scl_high;
            STOP: begin
                scl_o = scl_high;
                sda_o = (cnt_q >= SlotCntW'(SclHalfDiv + SclHalfDiv / 2));
            end
            default: begin
                scl_o = 1'b1;
                sda_o = 1'b1;
            end
        endcase
    end

    assign sel_od_pp_o = (state_q == BITS) && pp_q;

    assign stat_o.busy = (state_q != IDLE);
    assign stat_o.done = (state_q == STOP) && slot_end;
    assign stat_o.nack = nack_q;

endmodule

// ==== source/i3c_wrapper.sv ====
// Top level of the I3C controller subsystem: CSR front end, address table and frame serializer
`timescale 1ns/1ps

module i3c_wrapper import i3c_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,

    // Host register bus
    input  logic      csr_req_i,
    input  logic      csr_we_i,
    input  csr_addr_t csr_addr_i,
    input  csr_data_t csr_wdata_i,
    output csr_data_t csr_rdata_o,

    // I3C pads
    input  logic      scl_i,
    input  logic      sda_i,
    output logic      scl_o,
    output logic      sda_o,
    output logic      sda_oe_o,
    output logic      sel_od_pp_o,

    output logic      irq_o
);

    table_req_t table_req;
    table_rsp_t table_rsp;
    xfer_cmd_t  xfer_cmd;
    xfer_stat_t xfer_stat;

    i3c_csr_frontend u_csr_frontend (
        .clk_i,
        .rst_n_i,
        .csr_req_i,
        .csr_we_i,
        .csr_addr_i,
        .csr_wdata_i,
        .csr_rdata_o,
        .table_req_o (table_req),
        .table_rsp_i (table_rsp),
        .cmd_o       (xfer_cmd),
        .stat_i      (xfer_stat),
        .irq_o
    );

    i3c_table_ram u_table_ram (
        .clk_i,
        .rst_n_i,
        .req_i (table_req),
        .rsp_o (table_rsp)
    );

    i3c_addr_serializer u_addr_serializer (
        .clk_i,
        .rst_n_i,
        .cmd_i       (xfer_cmd),
        .stat_o      (xfer_stat),
        .scl_o,
        .sda_o,
        .sda_i,
        .sel_od_pp_o
    );

    // Pad enable: push-pull drives both levels, open drain only pulls low
    // scl_i is reserved for clock stretching and not looked at yet
    assign sda_oe_o = sel_od_pp_o || !sda_o;

endmodule

// ==== bench/i3c_wrapper_checker.sv ====
// Bound assertions on the I3C wrapper pads, idle bus and interrupt; attached to every i3c_wrapper
`timescale 1ns/1ps

module i3c_wrapper_checker import i3c_pkg::*; (
    input logic       clk_i,
    input logic       rst_n_i,
    input logic       scl_o,
    input logic       sda_o,
    input logic       sda_oe_o,
    input logic       sel_od_pp_o,
    input logic       irq_o,
    input xfer_stat_t stat_i
);

    int fail_cnt = 0;

    // Driven when push-pull or when pulling low
    sda_oe_truth: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        sda_oe_o == (sel_od_pp_o || !sda_o))
        else begin
            fail_cnt++;
            $error("sda_oe_o does not follow the pad truth table");
        end

    idle_bus: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !stat_i.busy |-> (scl_o && sda_o && !sel_od_pp_o))
        else begin
            fail_cnt++;
            $error("bus not idle while the serializer is not busy");
        end

    // irq only follows a done pulse
    irq_after_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(irq_o) |-> $past(stat_i.done))
        else begin
            fail_cnt++;
            $error("irq_o rose without a done pulse");
        end

endmodule

bind i3c_wrapper i3c_wrapper_checker u_checker (
    .clk_i,
    .rst_n_i,
    .scl_o,
    .sda_o,
    .sda_oe_o,
    .sel_od_pp_o,
    .irq_o,
    .stat_i (xfer_stat)
);

// ==== bench/tb_i3c_wrapper.sv ====
// Testbench for the I3C wrapper: table readback, address frames, dropped commands and status; run as top
`timescale 1ns/1ps

module tb_i3c_wrapper import i3c_pkg::*; ();

    // Address byte and ack slot as seen on the bus
    typedef struct packed {
        dyn_addr_t addr;
        logic      rnw;
        logic      ack;
    } frame_t;

    logic      clk_i       = 1'b0;
    logic      rst_n_i     = 1'b0;
    logic      csr_req_i   = 1'b0;
    logic      csr_we_i    = 1'b0;
    csr_addr_t csr_addr_i  = '0;
    csr_data_t csr_wdata_i = '0;
    csr_data_t csr_rdata_o;
    logic      scl_i       = 1'b1;
    logic      sda_i;
    logic      scl_o;
    logic      sda_o;
    logic      sda_oe_o;
    logic      sel_od_pp_o;
    logic      irq_o;

    int        seed        = 32'hfd14;
    int        cycle_cnt   = 0;
    int        cycle_limit = 5000;
    int        data_errs   = 0;
    int        frame_errs  = 0;
    int        bit_errs    = 0;
    int        other_errs  = 0;
    int        frames_seen = 0;
    dyn_addr_t resp_addr   = 7'h2c;
    logic      exp_pp      = 1'b0;
    logic      target_pull = 1'b0;
    frame_t    exp_q[$];
    frame_t    act_q[$];
    csr_data_t table_model [DatDepth];

    // Responder state
    logic       prev_scl   = 1'b1;
    logic       prev_sda   = 1'b1;
    logic       in_frame   = 1'b0;
    logic       data_phase = 1'b0;
    logic       ack_seen   = 1'b0;
    logic [7:0] shift_q    = '0;
    int         bit_cnt    = 0;

    i3c_wrapper u_i3c_wrapper (.*);

    // Open-drain line with pull-up, target may pull low
    assign sda_i = (sda_oe_o ? sda_o : 1'b1) && !target_pull;

    initial begin
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic check_data(input csr_data_t act, input csr_data_t exp, input string msg);
        if (act !== exp) begin
            data_errs++;
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, act, exp);
        end
    endtask

    task automatic check_frame(input frame_t act, input frame_t exp, input string msg);
        if (act !== exp) begin
            frame_errs++;
            $display("CHECK FAILED at %0t: %s, got addr %h rnw %b ack %b expected %h %b %b",
                     $time, msg, act.addr, act.rnw, act.ack, exp.addr, exp.rnw, exp.ack);
        end
    endtask

    task automatic check_bit(input logic act, input logic exp, input string msg);
        if (act !== exp) begin
            bit_errs++;
            $display("CHECK FAILED at %0t: %s, got %b expected %b", $time, msg, act, exp);
        end
    endtask

    // Expected bus frame: address MSB first, RnW, ack only from a matching target
    function automatic frame_t expected_frame(input dat_entry_t entry, input logic rnw,
                                              input dyn_addr_t target);
        expected_frame.addr = entry.dyn_addr;
        expected_frame.rnw  = rnw;
        expected_frame.ack  = (entry.dyn_addr == target);
    endfunction

    function automatic csr_data_t status_value(input logic done, input logic nack,
                                               input logic drop);
        status_value              = '0;
        status_value[StatDoneBit] = done;
        status_value[StatNackBit] = nack;
        status_value[StatDropBit] = drop;
    endfunction

    function automatic csr_addr_t dat_addr(input dat_idx_t idx);
        dat_addr = CsrAddrDatBase + csr_addr_t'({idx, 2'b00});
    endfunction

    task automatic csr_write(input csr_addr_t addr, input csr_data_t data);
        @(negedge clk_i);
        csr_req_i   = 1'b1;
        csr_we_i    = 1'b1;
        csr_addr_i  = addr;
        csr_wdata_i = data;
        @(negedge clk_i);
        csr_req_i = 1'b0;
        csr_we_i  = 1'b0;
    endtask

    task automatic csr_read(input csr_addr_t addr, output csr_data_t data);
        @(negedge clk_i);
        csr_req_i  = 1'b1;
        csr_we_i   = 1'b0;
        csr_addr_i = addr;
        @(negedge clk_i);
        csr_req_i = 1'b0;
        data      = csr_rdata_o;
    endtask

    task automatic poll_status(input int unsigned bit_pos, output csr_data_t status);
        do begin
            csr_read(CsrAddrStatus, status);
        end while (!status[bit_pos]);
    endtask

    task automatic launch_frame(input dat_idx_t idx, input dat_entry_t entry, input logic rnw);
        csr_data_t cmd;
        cmd               = '0;
        cmd[CmdRnwBit]    = rnw;
        cmd[DatAw-1:0]    = idx;
        csr_write(dat_addr(idx), csr_data_t'(entry));
        exp_pp = entry.push_pull;
        exp_q.push_back(expected_frame(entry, rnw, resp_addr));
        csr_write(CsrAddrCmd, cmd);
    endtask

    // Bus target: captures frames and acks its own address
    always @(negedge clk_i) begin : responder
        logic line_lvl;
        line_lvl = sda_i;
        if (!rst_n_i) begin
            in_frame    = 1'b0;
            data_phase  = 1'b0;
            target_pull = 1'b0;
        end else begin
            if (scl_o && prev_scl && prev_sda && !line_lvl) begin
                in_frame = 1'b1;
                bit_cnt  = 0;
                shift_q  = '0;
                ack_seen = 1'b0;
            end else if (in_frame && scl_o && !prev_scl) begin
                if (bit_cnt < 8) begin
                    shift_q = {shift_q[6:0], line_lvl};
                end else if (bit_cnt == 8) begin
                    ack_seen = !line_lvl;
                end
                bit_cnt++;
            end else if (in_frame && !scl_o && prev_scl) begin
                if (bit_cnt == 0) begin
                    data_phase = 1'b1;
                end
                if (bit_cnt == 8) begin
                    data_phase  = 1'b0;
                    target_pull = (shift_q[7:1] == resp_addr);
                end
                if (bit_cnt == 9) begin
                    target_pull = 1'b0;
                end
            end else if (in_frame && scl_o && prev_scl && !prev_sda && line_lvl) begin
                act_q.push_back(frame_t'({shift_q, ack_seen}));
                frames_seen++;
                in_frame = 1'b0;
            end
            // Pad mode during and outside the data bits
            if (data_phase) begin
                check_bit(sel_od_pp_o, exp_pp, "sel_od_pp_o during data bits");
                if (exp_pp) begin
                    check_bit(sda_oe_o, 1'b1, "sda_oe_o in push-pull data bits");
                end else if (sda_o) begin
                    check_bit(sda_oe_o, 1'b0, "sda_oe_o with open drain high");
                end
            end else begin
                check_bit(sel_od_pp_o, 1'b0, "sel_od_pp_o outside data bits");
            end
        end
        prev_scl = scl_o;
        prev_sda = line_lvl;
    end

    always @(negedge clk_i) begin : compare_frames
        frame_t act_f;
        frame_t exp_f;
        if (act_q.size() > 0) begin
            act_f = act_q.pop_front();
            if (exp_q.size() == 0) begin
                other_errs++;
                $display("Unexpected frame on the bus at %0t", $time);
            end else begin
                exp_f = exp_q.pop_front();
                check_frame(act_f, exp_f, "address frame");
            end
        end
    end

    initial begin : main
        csr_data_t  rd;
        dat_entry_t entry;
        dat_idx_t   idx;
        logic       rnw;
        dyn_addr_t  diff;
        int         frames_before;
        int         assert_errs;
        int         total_errs;

        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        // Idle bus after reset
        check_bit(scl_o, 1'b1, "scl_o after reset");
        check_bit(sda_o, 1'b1, "sda_o after reset");
        check_bit(sda_oe_o, 1'b0, "sda_oe_o after reset");
        check_bit(sel_od_pp_o, 1'b0, "sel_od_pp_o after reset");
        check_bit(irq_o, 1'b0, "irq_o after reset");
        csr_read(CsrAddrStatus, rd);
        check_data(rd, '0, "status after reset");

        for (int i = 0; i < DatDepth; i++) begin
            table_model[i] = $random(seed);
            csr_write(dat_addr(dat_idx_t'(i)), table_model[i]);
        end
        for (int i = 0; i < DatDepth; i++) begin
            csr_read(dat_addr(dat_idx_t'(i)), rd);
            check_data(rd, table_model[i], "table readback");
        end

        // Push-pull frame to the responder
        csr_write(CsrAddrStatus, 32'h7);
        idx            = dat_idx_t'($random(seed));
        entry          = dat_entry_t'($random(seed));
        entry.push_pull = 1'b1;
        entry.dyn_addr = resp_addr;
        rnw            = 1'($random(seed));
        frames_before  = frames_seen;
        launch_frame(idx, entry, rnw);
        poll_status(StatDoneBit, rd);
        check_data(rd, status_value(1'b1, 1'b0, 1'b0), "status after acked frame");
        check_bit(irq_o, 1'b1, "irq_o after done");
        check_data(csr_data_t'(frames_seen - frames_before), 32'd1, "frames per command");

        // Open drain to an address nobody answers
        csr_write(CsrAddrStatus, 32'h7);
        idx             = dat_idx_t'($random(seed));
        entry           = dat_entry_t'($random(seed));
        entry.push_pull = 1'b0;
        diff            = dyn_addr_t'($random(seed));
        if (diff == '0) begin
            diff = 7'h01;
        end
        entry.dyn_addr = resp_addr ^ diff;
        rnw            = 1'($random(seed));
        launch_frame(idx, entry, rnw);
        poll_status(StatDoneBit, rd);
        check_data(rd, status_value(1'b1, 1'b1, 1'b0), "status after nacked frame");

        // Second command while busy
        csr_write(CsrAddrStatus, 32'h7);
        idx             = dat_idx_t'($random(seed));
        entry           = dat_entry_t'($random(seed));
        entry.dyn_addr  = resp_addr;
        rnw             = 1'($random(seed));
        frames_before   = frames_seen;
        launch_frame(idx, entry, rnw);
        poll_status(StatBusyBit, rd);
        csr_write(CsrAddrCmd, csr_data_t'(dat_idx_t'(idx + 1'b1)));
        poll_status(StatDoneBit, rd);
        check_data(rd, status_value(1'b1, 1'b0, 1'b1), "status after dropped command");
        // Room for a stray second frame to reach its STOP
        repeat (12 * SlotCycles) @(negedge clk_i);
        check_data(csr_data_t'(frames_seen - frames_before), 32'd1, "frames with a drop");

        // W1C clears everything, unmapped reads zero
        csr_write(CsrAddrStatus, 32'h7);
        csr_read(CsrAddrStatus, rd);
        check_data(rd, '0, "status after W1C");
        check_bit(irq_o, 1'b0, "irq_o after W1C");
        csr_read(dat_addr(idx), rd);
        check_data(rd, csr_data_t'(entry), "table entry before unmapped read");
        csr_read(8'h20, rd);
        check_data(rd, '0, "unmapped read");

        repeat (4) @(negedge clk_i);
        if (exp_q.size() != 0) begin
            other_errs++;
            $display("%0d expected frames never appeared on the bus", exp_q.size());
        end
        assert_errs = u_i3c_wrapper.u_checker.fail_cnt;
        total_errs  = data_errs + frame_errs + bit_errs + other_errs + assert_errs;
        $display("Errors: data %0d, frame %0d, pad %0d, other %0d, assertion %0d",
                 data_errs, frame_errs, bit_errs, other_errs, assert_errs);
        if (total_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== i3c_wrapper.f ====
source/i3c_pkg.sv
source/i3c_csr_frontend.sv
source/i3c_table_ram.sv
source/i3c_addr_serializer.sv
source/i3c_wrapper.sv
bench/i3c_wrapper_checker.sv
bench/tb_i3c_wrapper.sv

// ==== Bender.yml ====
package:
  name: i3c_wrapper

sources:
  # RTL in compile order
  - files:
      - source/i3c_pkg.sv
      - source/i3c_csr_frontend.sv
      - source/i3c_table_ram.sv
      - source/i3c_addr_serializer.sv
      - source/i3c_wrapper.sv

  # Testbench and bound assertions
  - target: test
    files:
      - bench/i3c_wrapper_checker.sv
      - bench/tb_i3c_wrapper.sv
